//--- flist.f
+incdir+common
+incdir+test
common/nkmm_pkg.sv
common/nkmm_dbus_if.sv
cpu/nkmm_alu.sv
cpu/nkmm_regfile.sv
cpu/nkmm_cpu.sv
design/nkmm_prog_mem.sv
design/nkmm_data_mem.sv
design/nkmm_soc.sv
test/tb_nkmm_soc.sv

//--- test/nkmm_tb_programs.svh
// test programs, one block per entry
// put() adds an instruction word, emit() stores a register to the port and
// records the word expected there, park() ends the program in a jump to self

task automatic fill_programs();
    // add, sub, or, and, xor and not on K = 32'h12345678
    start_program("alu_imm");
    put(alu_ri(RA, ADD, R0, 16'h1234));
    put(shift_ri(RA, RA, 1'b1, 8));
    put(shift_ri(RA, RA, 1'b1, 8));
    put(alu_ri(RA, OR, RA, 16'h5678));
    put(alu_ri(RB, ADD, R0, 16'habcd));
    put(alu_rr(RC, ADD, RA, RB));
    emit(RC, 32'h12345678 + 32'h0000abcd);
    put(alu_ri(RC, SUB, RA, 16'habcd));
    emit(RC, 32'h12345678 - 32'h0000abcd);
    put(alu_rr(RC, OR, RA, RB));
    emit(RC, 32'h12345678 | 32'h0000abcd);
    put(alu_ri(RC, AND, RA, 16'hf0f0));
    emit(RC, 32'h12345678 & 32'h0000f0f0);
    put(alu_ri(RC, XOR, RA, 16'hffff));
    emit(RC, 32'h12345678 ^ 32'h0000ffff);
    put(alu_rr(RC, NOT, R0, RA));
    emit(RC, ~32'h12345678);
    park();

    // readers one, two and three slots after the writer
    start_program("dep_chain");
    put(alu_ri(RA, ADD, R0, 16'd5));
    put(alu_ri(RB, ADD, RA, 16'd3));
    put(alu_ri(RC, ADD, R0, 16'd100));
    put(alu_ri(RD, ADD, RB, 16'd1));
    put(alu_ri(RE, ADD, R0, 16'd7));
    put(alu_ri(SP, ADD, R0, 16'd1));
    put(alu_rr(RA, ADD, RD, RE));
    emit(RA, 32'd16);
    emit(RB, 32'd8);
    emit(RD, 32'd9);
    put(alu_rr(SP, ADD, RA, RC));
    emit(SP, 32'd116);
    park();

    // both ends lose bits, K = 32'h84211249
    start_program("shifts");
    put(alu_ri(RA, ADD, R0, 16'h8421));
    put(shift_ri(RA, RA, 1'b1, 8));
    put(shift_ri(RA, RA, 1'b1, 8));
    put(alu_ri(RA, OR, RA, 16'h1249));
    put(shift_ri(RB, RA, 1'b1, 1));
    emit(RB, 32'h84211249 << 1);
    put(shift_ri(RB, RA, 1'b1, 2));
    emit(RB, 32'h84211249 << 2);
    put(shift_ri(RB, RA, 1'b1, 4));
    emit(RB, 32'h84211249 << 4);
    put(shift_ri(RB, RA, 1'b1, 8));
    emit(RB, 32'h84211249 << 8);
    put(shift_ri(RB, RA, 1'b0, 1));
    emit(RB, 32'h84211249 >> 1);
    put(shift_ri(RB, RA, 1'b0, 2));
    emit(RB, 32'h84211249 >> 2);
    put(shift_ri(RB, RA, 1'b0, 4));
    emit(RB, 32'h84211249 >> 4);
    put(shift_ri(RB, RA, 1'b0, 8));
    emit(RB, 32'h84211249 >> 8);
    park();

    // two words out to the data ram and back
    start_program("mem_roundtrip");
    put(alu_ri(RA, ADD, R0, 16'hbeef));
    put(alu_ri(RB, ADD, R0, 16'h1234));
    put(store_word(RA, R0, 16'd10));
    put(store_word(RB, R0, 16'd11));
    put(load_word(RC, R0, 16'd10));
    put(load_word(RD, R0, 16'd11));
    emit(RC, 32'h0000beef);
    emit(RD, 32'h00001234);
    park();

    // words 2 and 3 are skipped, r0 ignores the write at 4
    start_program("jump_r0");
    put(alu_ri(RA, ADD, R0, 16'h0011));
    put(alu_ri(PC, ADD, R0, 16'd4));
    put(alu_ri(RA, ADD, R0, 16'h0099));
    put(store_word(RA, R0, PORT_ADDR));
    put(alu_ri(R0, ADD, R0, 16'h0055));
    emit(R0, 32'h00000000);
    emit(RA, 32'h00000011);
    park();
endtask

//--- test/tb_nkmm_soc.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module tb_nkmm_soc;

    localparam int NUM_PROGS    = 5;
    localparam int MAX_WORDS    = 32;
    localparam int MAX_OUTS     = 8;
    localparam int OUT_TIMEOUT  = 200;
    localparam int QUIET_CYCLES = 60;
    localparam logic [15:0] PORT_ADDR = 16'd255;

    // select and operation codes as they sit in the instruction word
    typedef enum logic [2:0] {R0, RA, RB, RC, RD, RE, SP, PC} reg_t;
    typedef enum logic [2:0] {ADD, SUB, OR, AND, XOR, NOT, SHI} op_t;

    logic                    clk;
    logic                    rst;
    logic                    prog_we;
    logic [`ADDR_WIDTH-1:0]  prog_waddr;
    logic [`INSN_WIDTH-1:0]  prog_wdata;
    logic                    out_valid;
    logic [`ACCUM_WIDTH-1:0] out_data;

    // program table
    string       prog_name  [NUM_PROGS];
    logic [31:0] prog_words [NUM_PROGS][MAX_WORDS];
    int          prog_len   [NUM_PROGS];
    logic [31:0] exp_words  [NUM_PROGS][MAX_OUTS];
    int          exp_count  [NUM_PROGS];
    int          cur = -1;

    nkmm_soc u_dut (
        .clk          (clk),
        .rst          (rst),
        .prog_we_i    (prog_we),
        .prog_waddr_i (prog_waddr),
        .prog_wdata_i (prog_wdata),
        .out_valid_o  (out_valid),
        .out_data_o   (out_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] insn(input logic mw, input logic mr, input reg_t d,
                                         input op_t op, input reg_t a, input reg_t b,
                                         input logic ie, input logic [15:0] imm);
        return {1'b0, mw, mr, d, op, a, b, ie, imm};
    endfunction

    function automatic logic [31:0] alu_rr(input reg_t d, input op_t op, input reg_t a,
                                           input reg_t b);
        return insn(1'b0, 1'b0, d, op, a, b, 1'b0, 16'h0);
    endfunction

    function automatic logic [31:0] alu_ri(input reg_t d, input op_t op, input reg_t a,
                                           input logic [15:0] imm);
        return insn(1'b0, 1'b0, d, op, a, R0, 1'b1, imm);
    endfunction

    // b[2] picks left, b[1:0] codes 1, 2, 4 or 8
    function automatic logic [31:0] shift_ri(input reg_t d, input reg_t a, input logic left,
                                             input int amount);
        logic [1:0] code;
        code = (amount == 1) ? 2'd0 : (amount == 2) ? 2'd1 : (amount == 4) ? 2'd2 : 2'd3;
        return alu_ri(d, SHI, a, {13'h0, left, code});
    endfunction

    // data address is a + imm, the d field names the stored register
    function automatic logic [31:0] store_word(input reg_t src, input reg_t a,
                                               input logic [15:0] imm);
        return insn(1'b1, 1'b0, src, ADD, a, R0, 1'b1, imm);
    endfunction

    function automatic logic [31:0] load_word(input reg_t d, input reg_t a,
                                              input logic [15:0] imm);
        return insn(1'b0, 1'b1, d, ADD, a, R0, 1'b1, imm);
    endfunction

    task automatic start_program(input string name);
        cur++;
        prog_name[cur] = name;
        prog_len[cur]  = 0;
        exp_count[cur] = 0;
        // all-zero padding adds r0 to r0
        for (int i = 0; i < MAX_WORDS; i++) begin
            prog_words[cur][i] = '0;
        end
    endtask

    task automatic put(input logic [31:0] word);
        prog_words[cur][prog_len[cur]] = word;
        prog_len[cur]++;
    endtask

    task automatic emit(input reg_t src, input logic [31:0] expected);
        put(store_word(src, R0, PORT_ADDR));
        exp_words[cur][exp_count[cur]] = expected;
        exp_count[cur]++;
    endtask

    task automatic park();
        put(alu_ri(PC, ADD, R0, 16'(prog_len[cur])));
    endtask

    `include "nkmm_tb_programs.svh"

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic run_program(input int p);
        int waited;
        rst = 1'b1;
        // reset stays high through loading, then 8 more cycles
        for (int i = 0; i < MAX_WORDS; i++) begin
            step();
            assert (!out_valid)
                else stop_with_error($sformatf("%s: output valid while loading", prog_name[p]));
            prog_we    = 1'b1;
            prog_waddr = `ADDR_WIDTH'(i);
            prog_wdata = prog_words[p][i];
        end
        step();
        prog_we = 1'b0;
        repeat (8) begin
            step();
            assert (!out_valid)
                else stop_with_error($sformatf("%s: output valid during reset", prog_name[p]));
        end
        rst = 1'b0;

        for (int k = 0; k < exp_count[p]; k++) begin
            waited = 0;
            do begin
                step();
                waited++;
            end while (!out_valid && waited < OUT_TIMEOUT);
            assert (out_valid)
                else stop_with_error($sformatf("%s: output %0d never came within %0d cycles",
                                               prog_name[p], k, OUT_TIMEOUT));
            assert (out_data === exp_words[p][k])
                else stop_with_error($sformatf("Fail %s output %0d: expected %h, actual %h",
                                               prog_name[p], k, exp_words[p][k], out_data));
        end

        // nothing may follow the last expected word
        repeat (QUIET_CYCLES) begin
            step();
            assert (!out_valid)
                else stop_with_error($sformatf("%s: unexpected extra output %h",
                                               prog_name[p], out_data));
        end
        $display("%s: %0d outputs matched", prog_name[p], exp_count[p]);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        prog_we    = 1'b0;
        prog_waddr = '0;
        prog_wdata = '0;
        fill_programs();
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- design/nkmm_soc.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module nkmm_soc (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    prog_we_i,
    input  logic [`ADDR_WIDTH-1:0]  prog_waddr_i,
    input  logic [`INSN_WIDTH-1:0]  prog_wdata_i,
    output logic                    out_valid_o,
    output logic [`ACCUM_WIDTH-1:0] out_data_o
);

    logic [`ADDR_WIDTH-1:0] prog_addr;
    logic [`INSN_WIDTH-1:0] prog_data;

    nkmm_dbus_if dbus ();

    nkmm_cpu u_cpu (
        .clk         (clk),
        .rst         (rst),
        .prog_addr_o (prog_addr),
        .prog_data_i (prog_data),
        .dbus        (dbus.cpu)
    );

    // loaded from outside while the cpu sits in reset
    nkmm_prog_mem u_prog_mem (
        .clk       (clk),
        .rd_addr_i (prog_addr),
        .rd_data_o (prog_data),
        .wr_en_i   (prog_we_i),
        .wr_addr_i (prog_waddr_i),
        .wr_data_i (prog_wdata_i)
    );

    nkmm_data_mem u_data_mem (
        .clk         (clk),
        .rst         (rst),
        .bus         (dbus.mem),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o)
    );

endmodule

//--- design/nkmm_data_mem.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module nkmm_data_mem (
    input  logic                    clk,
    input  logic                    rst,
    nkmm_dbus_if.mem                bus,
    output logic                    out_valid_o,
    output logic [`ACCUM_WIDTH-1:0] out_data_o
);

    logic [`ACCUM_WIDTH-1:0] ram [0:`MEM_DEPTH-1];
    logic                    out_hit;
    logic                    out_valid_ff;
    logic [`ACCUM_WIDTH-1:0] out_data_ff;

    assign out_hit = bus.we && bus.addr == `OUT_PORT_ADDR;

    // port address never lands in the ram
    always_ff @(posedge clk) begin
        if (bus.we && !out_hit) begin
            ram[bus.addr] <= bus.wdata;
        end
        bus.rdata <= ram[bus.addr];
    end

    // one-cycle pulse per store to the port
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_ff <= 1'b0;
        end else begin
            out_valid_ff <= out_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (out_hit) begin
            out_data_ff <= bus.wdata;
        end
    end

    assign out_valid_o = out_valid_ff;
    assign out_data_o  = out_data_ff;

endmodule

//--- design/nkmm_prog_mem.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module nkmm_prog_mem (
    input  logic                   clk,
    input  logic [`ADDR_WIDTH-1:0] rd_addr_i,
    output logic [`INSN_WIDTH-1:0] rd_data_o,
    input  logic                   wr_en_i,
    input  logic [`ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [`INSN_WIDTH-1:0] wr_data_i
);

    logic [`INSN_WIDTH-1:0] mem [0:`MEM_DEPTH-1];

    // loading port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // fetch word arrives one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- cpu/nkmm_cpu.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module nkmm_cpu import nkmm_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`ADDR_WIDTH-1:0] prog_addr_o,
    input  logic [`INSN_WIDTH-1:0] prog_data_i,
    nkmm_dbus_if.cpu               dbus
);

    // fetch
    logic [`ADDR_WIDTH-1:0]  pc_ff;
    logic                    fetch_valid_ff;
    logic                    stall_ff;
    logic [`INSN_WIDTH-1:0]  held_insn_ff;

    // decode
    logic [`INSN_WIDTH-1:0]  dcd_insn;
    logic                    dcd_in_valid;
    insn_fields_t            dcd_f;
    logic                    stall;
    logic [`ACCUM_WIDTH-1:0] rf_a;
    logic [`ACCUM_WIDTH-1:0] rf_b;
    logic [`ACCUM_WIDTH-1:0] rf_d;
    logic                    dcd_valid_ff;
    logic                    dcd_mem_write_ff;
    logic                    dcd_mem_read_ff;
    opsel_e                  dcd_op_ff;
    logic [`ACCUM_WIDTH-1:0] dcd_alu_a_ff;
    logic [`ACCUM_WIDTH-1:0] dcd_alu_b_ff;
    logic [`ACCUM_WIDTH-1:0] dcd_reg_d_ff;
    regsel_e                 dcd_d_sel_ff;

    // execute
    logic [`ACCUM_WIDTH-1:0] alu_r;
    logic                    ex_valid_ff;
    logic                    ex_mem_write_ff;
    logic                    ex_mem_read_ff;
    logic [`ACCUM_WIDTH-1:0] ex_alu_r_ff;
    logic [`ACCUM_WIDTH-1:0] ex_reg_d_ff;
    regsel_e                 ex_d_sel_ff;

    // memory and writeback
    logic                    mio_valid_ff;
    logic                    mio_mem_write_ff;
    logic                    mio_mem_read_ff;
    logic [`ACCUM_WIDTH-1:0] mio_alu_r_ff;
    regsel_e                 mio_d_sel_ff;
    logic [`ACCUM_WIDTH-1:0] wb_data;
    logic                    wb_en;
    logic                    jump;

    // older insn will write a register the decoding one reads
    function automatic logic hazard(input logic valid, input logic is_store,
                                    input regsel_e dst, input insn_fields_t f);
        logic reads;
        reads = (f.a_sel == dst) || (!f.imm_en && f.b_sel == dst) ||
                (f.mem_write && f.d_sel == dst);
        return valid && !is_store && dst != SEL_R0 && reads;
    endfunction

    assign prog_addr_o = pc_ff;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_ff          <= '0;
            fetch_valid_ff <= 1'b0;
            stall_ff       <= 1'b0;
        end else begin
            fetch_valid_ff <= !jump;
            stall_ff       <= stall && !jump;
            if (jump) begin
                pc_ff <= wb_data[`ADDR_WIDTH-1:0];
            end else if (!stall) begin
                pc_ff <= pc_ff + `ADDR_WIDTH'(1);
            end
        end
    end

    // memory already moved on while stalled, replay the held word
    always_ff @(posedge clk) begin
        held_insn_ff <= dcd_insn;
    end

    assign dcd_insn     = stall_ff ? held_insn_ff : prog_data_i;
    assign dcd_in_valid = stall_ff || fetch_valid_ff;
    assign dcd_f        = nkmm_decode(dcd_insn);

    assign stall = dcd_in_valid &&
                   (hazard(dcd_valid_ff, dcd_mem_write_ff, dcd_d_sel_ff, dcd_f) ||
                    hazard(ex_valid_ff, ex_mem_write_ff, ex_d_sel_ff, dcd_f) ||
                    hazard(mio_valid_ff, mio_mem_write_ff, mio_d_sel_ff, dcd_f));

    nkmm_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .a_sel_i   (dcd_f.a_sel),
        .b_sel_i   (dcd_f.b_sel),
        .d_sel_i   (dcd_f.d_sel),
        .pc_i      (pc_ff),
        .a_o       (rf_a),
        .b_o       (rf_b),
        .d_o       (rf_d),
        .wr_en_i   (wb_en),
        .wr_sel_i  (mio_d_sel_ff),
        .wr_data_i (wb_data)
    );

    // stall inserts a bubble, jump squashes everything younger
    always_ff @(posedge clk) begin
        if (rst) begin
            dcd_valid_ff <= 1'b0;
            ex_valid_ff  <= 1'b0;
            mio_valid_ff <= 1'b0;
        end else begin
            dcd_valid_ff <= dcd_in_valid && !stall && !jump;
            ex_valid_ff  <= dcd_valid_ff && !jump;
            mio_valid_ff <= ex_valid_ff && !jump;
        end
    end

    always_ff @(posedge clk) begin
        dcd_mem_write_ff <= dcd_f.mem_write;
        dcd_mem_read_ff  <= dcd_f.mem_read;
        dcd_op_ff        <= dcd_f.op;
        dcd_alu_a_ff     <= rf_a;
        dcd_alu_b_ff     <= dcd_f.imm_en ?
                            {{(`ACCUM_WIDTH-`IMM_WIDTH){1'b0}}, dcd_f.imm} : rf_b;
        dcd_reg_d_ff     <= rf_d;
        dcd_d_sel_ff     <= dcd_f.d_sel;
    end

    nkmm_alu u_alu (
        .op_i     (dcd_op_ff),
        .a_i      (dcd_alu_a_ff),
        .b_i      (dcd_alu_b_ff),
        .result_o (alu_r)
    );

    always_ff @(posedge clk) begin
        ex_mem_write_ff <= dcd_mem_write_ff;
        ex_mem_read_ff  <= dcd_mem_read_ff;
        ex_alu_r_ff     <= alu_r;
        ex_reg_d_ff     <= dcd_reg_d_ff;
        ex_d_sel_ff     <= dcd_d_sel_ff;
    end

    // alu result is the data address, d register the store data
    assign dbus.addr  = ex_alu_r_ff[`ADDR_WIDTH-1:0];
    assign dbus.wdata = ex_reg_d_ff;
    assign dbus.we    = ex_valid_ff && ex_mem_write_ff && !jump;

    always_ff @(posedge clk) begin
        mio_mem_write_ff <= ex_mem_write_ff;
        mio_mem_read_ff  <= ex_mem_read_ff;
        mio_alu_r_ff     <= ex_alu_r_ff;
        mio_d_sel_ff     <= ex_d_sel_ff;
    end

    // stores write no register
    assign wb_data = mio_mem_read_ff ? dbus.rdata : mio_alu_r_ff;
    assign wb_en   = mio_valid_ff && !mio_mem_write_ff;
    assign jump    = wb_en && mio_d_sel_ff == SEL_PC;

endmodule

//--- cpu/nkmm_regfile.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module nkmm_regfile import nkmm_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  regsel_e                 a_sel_i,
    input  regsel_e                 b_sel_i,
    input  regsel_e                 d_sel_i,
    input  logic [`ADDR_WIDTH-1:0]  pc_i,
    output logic [`ACCUM_WIDTH-1:0] a_o,
    output logic [`ACCUM_WIDTH-1:0] b_o,
    output logic [`ACCUM_WIDTH-1:0] d_o,
    input  logic                    wr_en_i,
    input  regsel_e                 wr_sel_i,
    input  logic [`ACCUM_WIDTH-1:0] wr_data_i
);

    // ra..sp, indexed by select code
    logic [`ACCUM_WIDTH-1:0] regs_ff [1:6];

    function automatic logic [`ACCUM_WIDTH-1:0] read_sel(input regsel_e sel);
        case (sel)
            SEL_R0:  return '0;
            SEL_PC:  return {{(`ACCUM_WIDTH-`ADDR_WIDTH){1'b0}}, pc_i};
            default: return regs_ff[sel];
        endcase
    endfunction

    always_comb begin
        a_o = read_sel(a_sel_i);
        b_o = read_sel(b_sel_i);
        d_o = read_sel(d_sel_i);
    end

    // r0 is hard zero, pc writes are jumps and live in the cpu
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= 6; i++) begin
                regs_ff[i] <= '0;
            end
        end else if (wr_en_i && wr_sel_i != SEL_R0 && wr_sel_i != SEL_PC) begin
            regs_ff[wr_sel_i] <= wr_data_i;
        end
    end

endmodule

//--- cpu/nkmm_alu.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

module nkmm_alu import nkmm_pkg::*; (
    input  opsel_e                  op_i,
    input  logic [`ACCUM_WIDTH-1:0] a_i,
    input  logic [`ACCUM_WIDTH-1:0] b_i,
    output logic [`ACCUM_WIDTH-1:0] result_o
);

    shi_e                    shi_amt;
    logic                    shl;
    logic [3:0]              shamt;
    logic [`ACCUM_WIDTH-1:0] shifted;

    // shift operand packed in b
    assign shi_amt = shi_e'(b_i[1:0]);
    assign shl     = b_i[2];

    always_comb begin
        case (shi_amt)
            SHI_1:   shamt = 4'd1;
            SHI_2:   shamt = 4'd2;
            SHI_4:   shamt = 4'd4;
            default: shamt = 4'd8;
        endcase
    end

    assign shifted = shl ? (a_i << shamt) : (a_i >> shamt);

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_AND:  result_o = a_i & b_i;
            OP_XOR:  result_o = a_i ^ b_i;
            // unary on b
            OP_NOT:  result_o = ~b_i;
            OP_SHI:  result_o = shifted;
            default: result_o = '0;
        endcase
    end

endmodule

//--- common/nkmm_dbus_if.sv
`timescale 1ns/1ns
`include "nkmm_consts.svh"

// cpu to data memory, no handshake
interface nkmm_dbus_if;
    logic [`ADDR_WIDTH-1:0]  addr;
    logic [`ACCUM_WIDTH-1:0] wdata;
    logic                    we;
    // valid the cycle after addr
    logic [`ACCUM_WIDTH-1:0] rdata;

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );
endinterface

//--- common/nkmm_pkg.sv
`include "nkmm_consts.svh"

package nkmm_pkg;

    // alu operations, code 7 has no meaning
    typedef enum logic [`OPSEL_WIDTH-1:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_OR  = 3'd2,
        OP_AND = 3'd3,
        OP_XOR = 3'd4,
        OP_NOT = 3'd5,
        OP_SHI = 3'd6
    } opsel_e;

    typedef enum logic [`REGSEL_WIDTH-1:0] {
        SEL_R0 = 3'd0,
        SEL_RA = 3'd1,
        SEL_RB = 3'd2,
        SEL_RC = 3'd3,
        SEL_RD = 3'd4,
        SEL_RE = 3'd5,
        SEL_SP = 3'd6,
        SEL_PC = 3'd7
    } regsel_e;

    // shift amount in b[1:0], direction in b[2]
    typedef enum logic [1:0] {
        SHI_1 = 2'd0,
        SHI_2 = 2'd1,
        SHI_4 = 2'd2,
        SHI_8 = 2'd3
    } shi_e;

    typedef struct packed {
        logic                  mem_write;
        logic                  mem_read;
        regsel_e               d_sel;
        opsel_e                op;
        regsel_e               a_sel;
        regsel_e               b_sel;
        logic                  imm_en;
        logic [`IMM_WIDTH-1:0] imm;
    } insn_fields_t;

    function automatic insn_fields_t nkmm_decode(input logic [`INSN_WIDTH-1:0] insn);
        insn_fields_t f;
        f.mem_write = insn[30];
        f.mem_read  = insn[29];
        f.d_sel     = regsel_e'(insn[28:26]);
        f.op        = opsel_e'(insn[25:23]);
        f.a_sel     = regsel_e'(insn[22:20]);
        f.b_sel     = regsel_e'(insn[19:17]);
        f.imm_en    = insn[16];
        f.imm       = insn[15:0];
        return f;
    endfunction

endpackage

//--- common/nkmm_consts.svh
`ifndef NKMM_CONSTS_SVH
`define NKMM_CONSTS_SVH

// instruction word
`define INSN_WIDTH 32

// register, alu and data word
`define ACCUM_WIDTH 32

// program and data addresses share one width
`define ADDR_WIDTH 8

// words in each memory
`define MEM_DEPTH (1 << `ADDR_WIDTH)

// instruction field widths
`define REGSEL_WIDTH 3
`define OPSEL_WIDTH 3
`define IMM_WIDTH 16

// a store here goes to the output port, not to the ram
`define OUT_PORT_ADDR 8'd255

`endif
